/* dv/pit_model.svh */
`ifndef PIT_MODEL_SVH
`define PIT_MODEL_SVH

pit_request_t model_interests [$];
pit_request_t model_data [$];
bit model_slot_valid [TABLE_SLOTS];
pit_request_t model_slot [TABLE_SLOTS];
logic [INDEX_BITS-1:0] model_salt;
int unsigned model_count [OUTCOME_COUNT]; // indexed by outcome
pit_result_t expected_results [$];
longint expected_due [$]; // edge at which each expected result shows

// zero every bit past the len leading ones
function automatic pit_request_t mask_request(input pit_request_t req);
	pit_request_t masked;
	masked = req;
	for (int p = 0; p < PREFIX_BITS - int'(req.len); p++) begin
		masked.prefix[p] = 1'b0;
	end
	return masked;
endfunction

function automatic logic [INDEX_BITS-1:0] slot_of(input pit_request_t masked);
	logic [INDEX_BITS-1:0] index;
	index = model_salt;
	for (int c = 0; c < PREFIX_BITS; c += INDEX_BITS) begin
		index ^= INDEX_BITS'(masked.prefix >> c); // the last chunk only has 4 bits
	end
	return index;
endfunction

function automatic pit_result_t model_lookup(input pit_kind_e kind, input pit_request_t req);
	pit_request_t masked;
	pit_result_t res;
	bit same;
	masked = mask_request(req);
	res.kind = kind;
	res.table_entry = slot_of(masked);
	same = model_slot_valid[res.table_entry] && model_slot[res.table_entry] == masked;
	if (kind == kind_data) begin
		res.outcome = same ? outcome_satisfied : outcome_rejected;
		if (same) model_slot_valid[res.table_entry] = 1'b0;
	end else if (!model_slot_valid[res.table_entry]) begin
		res.outcome = outcome_inserted;
		model_slot_valid[res.table_entry] = 1'b1;
		model_slot[res.table_entry] = masked;
	end else begin
		res.outcome = same ? outcome_aggregated : outcome_rejected;
	end
	model_count[res.outcome]++;
	return res;
endfunction

// one rising edge, the pop sees the queues as they were before it
task automatic model_edge(input bit push_interest, input pit_request_t interest_req,
		input bit push_data, input pit_request_t data_req, input longint edge_at,
		output bit popped_interest, output bit popped_data);
	popped_data = model_data.size() != 0;
	popped_interest = !popped_data && model_interests.size() != 0;
	if ((push_interest && model_interests.size() == INGRESS_DEPTH) ||
			(push_data && model_data.size() == INGRESS_DEPTH)) begin
		fail_run("a request was pushed into a full ingress queue");
	end
	if (popped_data) begin
		expected_results.push_back(model_lookup(kind_data, model_data.pop_front()));
		expected_due.push_back(edge_at + 2);
	end else if (popped_interest) begin
		expected_results.push_back(model_lookup(kind_interest, model_interests.pop_front()));
		expected_due.push_back(edge_at + 2);
	end
	if (push_interest) model_interests.push_back(interest_req);
	if (push_data) model_data.push_back(data_req);
endtask

`endif

/* dv/pit_tb.sv */
module pit_tb;
	import pit_pkg::*;

	localparam int REQUESTS = 400;
	localparam int POOL_SIZE = 12;

	logic clk;
	logic reset;
	logic interest_valid;
	pit_request_t interest;
	logic data_valid;
	pit_request_t data;
	logic interest_credit;
	logic data_credit;
	logic result_valid;
	pit_result_t result;
	logic cfg_write;
	logic [CFG_ADDR_BITS-1:0] cfg_addr;
	logic [CFG_DATA_BITS-1:0] cfg_wdata;
	logic [CFG_DATA_BITS-1:0] cfg_rdata;

	integer seed;
	pit_request_t pool [POOL_SIZE];
	int credits [2]; // sender side, 0 interests and 1 data
	int sent;
	longint edge_no;

	`include "pit_model.svh"

	pit_top i_dut (.*);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// checks

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic compare_result(input pit_result_t expected, input pit_result_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED at %0t: result expected %h got %h",
				$time, expected, actual));
		end
	endtask

	task automatic compare_counter(input string name, input logic [CFG_DATA_BITS-1:0] expected,
			input logic [CFG_DATA_BITS-1:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED at %0t: %s expected %0d got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED at %0t: %s expected %b got %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic read_register(input logic [CFG_ADDR_BITS-1:0] addr, input string name,
			input logic [CFG_DATA_BITS-1:0] expected);
		cfg_addr = addr;
		#1 compare_counter(name, expected, cfg_rdata);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	// random names, then twins that share a fold and twins that differ only past len
	task automatic build_pool();
		for (int n = 0; n < POOL_SIZE; n++) begin
			pool[n].prefix = {$random(seed), $random(seed)};
			pool[n].len = LEN_BITS'($unsigned($random(seed)) % (PREFIX_BITS + 1));
		end
		for (int n = 0; n < 4; n++) begin
			pool[n].len = LEN_BITS'(8 + n * 12); // keeps bits 63 and 57 inside the name
			pool[n + 4] = pool[n];
			if (n % 2 == 0) pool[n + 4].prefix ^= {1'b1, 5'b0, 1'b1, 57'b0};
			else pool[n + 4].prefix ^= {$random(seed), $random(seed)} >> pool[n].len;
		end
	endtask

	// runs just after a rising edge, once the DUT outputs have settled
	task automatic run_cycle(input bit may_send);
		bit popped_interest;
		bit popped_data;
		@(posedge clk);
		#1;
		edge_no++;
		model_edge(interest_valid, interest, data_valid, data, edge_no,
			popped_interest, popped_data);
		compare_flag("interest_credit", popped_interest, interest_credit);
		compare_flag("data_credit", popped_data, data_credit);
		credits[0] += int'(interest_credit);
		credits[1] += int'(data_credit);
		if (expected_due.size() != 0 && expected_due[0] == edge_no) begin
			compare_flag("result_valid", 1'b1, result_valid);
			compare_result(expected_results.pop_front(), result);
			void'(expected_due.pop_front());
		end else begin
			compare_flag("result_valid", 1'b0, result_valid);
		end
		interest_valid = 1'b0;
		data_valid = 1'b0;
		if (may_send && credits[0] > 0 && $unsigned($random(seed)) % 4 != 0) begin
			interest_valid = 1'b1;
			interest = pool[$unsigned($random(seed)) % POOL_SIZE];
			credits[0]--;
			sent++;
		end
		if (may_send && credits[1] > 0 && $unsigned($random(seed)) % 2 != 0) begin
			data_valid = 1'b1;
			data = pool[$unsigned($random(seed)) % POOL_SIZE];
			credits[1]--;
			sent++;
		end
	endtask

	initial begin
		#((20 * REQUESTS + 200) * 10);
		fail_run("watchdog expired because results stopped arriving");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		interest_valid = 1'b0;
		interest = '0;
		data_valid = 1'b0;
		data = '0;
		cfg_write = 1'b0;
		cfg_addr = CFG_SALT;
		cfg_wdata = '0;
		seed = 32'h60c4;
		credits[0] = INGRESS_DEPTH;
		credits[1] = INGRESS_DEPTH;
		sent = 0;
		edge_no = 0;
		build_pool();
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		cfg_write = 1'b1; // nonzero salt before any traffic
		cfg_wdata = CFG_DATA_BITS'($unsigned($random(seed)) % 63 + 1);
		model_salt = cfg_wdata[INDEX_BITS-1:0];
		@(posedge clk);
		#1;
		cfg_write = 1'b0;
		while (sent < REQUESTS) run_cycle(1'b1);
		while (interest_valid || data_valid || expected_due.size() != 0 ||
				model_interests.size() != 0 || model_data.size() != 0) begin
			run_cycle(1'b0);
		end
		run_cycle(1'b0); // the last result reaches its counter here
		if (credits[0] != INGRESS_DEPTH || credits[1] != INGRESS_DEPTH) begin
			fail_run("not every ingress credit came back");
		end
		for (int k = 0; k < OUTCOME_COUNT; k++) begin
			if (model_count[k] == 0) fail_run("one of the four outcomes never occurred");
		end
		read_register(CFG_SALT, "salt", CFG_DATA_BITS'(model_salt));
		read_register(CFG_INSERTED, "inserted", model_count[outcome_inserted]);
		read_register(CFG_AGGREGATED, "aggregated", model_count[outcome_aggregated]);
		read_register(CFG_SATISFIED, "satisfied", model_count[outcome_satisfied]);
		read_register(CFG_REJECTED, "rejected", model_count[outcome_rejected]);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* pit_hash_table.f */
+incdir+dv
source/pit_pkg.sv
source/pit_prefix_hash.sv
source/pit_ingress.sv
source/pit_hash_table.sv
source/pit_config.sv
source/pit_top.sv
dv/pit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the PIT testbench with Verilator and runs it
# the exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	-f pit_hash_table.f \
	--top-module pit_tb \
	-o pit_tb
./obj_dir/pit_tb

/* source/pit_config.sv */
module pit_config (
	input logic clk,
	input logic reset,
	input logic cfg_write,
	input logic [pit_pkg::CFG_ADDR_BITS-1:0] cfg_addr,
	input logic [pit_pkg::CFG_DATA_BITS-1:0] cfg_wdata,
	output logic [pit_pkg::CFG_DATA_BITS-1:0] cfg_rdata,
	output logic [pit_pkg::INDEX_BITS-1:0] salt,
	input logic result_valid,
	input pit_pkg::pit_result_t result
);
	import pit_pkg::*;

	logic [CFG_DATA_BITS-1:0] counters [OUTCOME_COUNT]; // indexed by outcome

	////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge clk) begin
		if (reset) begin
			salt <= '0;
		end else if (cfg_write && cfg_addr == CFG_SALT) begin
			salt <= cfg_wdata[INDEX_BITS-1:0]; // upper write bits are dropped
		end
	end

	// counters are read-only, so config writes never touch them
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < OUTCOME_COUNT; i++) begin
				counters[i] <= '0;
			end
		end else if (result_valid) begin
			counters[result.outcome] <= counters[result.outcome] + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// read port

	always_comb begin
		case (cfg_addr)
			CFG_SALT: cfg_rdata = CFG_DATA_BITS'(salt);
			CFG_INSERTED: cfg_rdata = counters[outcome_inserted];
			CFG_AGGREGATED: cfg_rdata = counters[outcome_aggregated];
			CFG_SATISFIED: cfg_rdata = counters[outcome_satisfied];
			CFG_REJECTED: cfg_rdata = counters[outcome_rejected];
			default: cfg_rdata = '0; // unused addresses
		endcase
	end

endmodule

/* source/pit_hash_table.sv */
module pit_hash_table (
	input logic clk,
	input logic reset,
	input logic lookup_valid,
	input pit_pkg::pit_lookup_t lookup,
	output logic result_valid,
	output pit_pkg::pit_result_t result
);
	import pit_pkg::*;

	logic [TABLE_SLOTS-1:0] slot_valid;
	pit_request_t slot_request [TABLE_SLOTS];

	logic occupied;
	logic hit;
	pit_outcome_e outcome;

	////////////////////////////////////////////////////////////
	// decide

	// requests are stored masked, so a plain compare covers prefix and len
	assign occupied = slot_valid[lookup.index];
	assign hit = occupied && (slot_request[lookup.index] == lookup.request);

	always_comb begin
		if (lookup.kind == kind_interest) begin
			if (!occupied) begin
				outcome = outcome_inserted;
			end else if (hit) begin
				outcome = outcome_aggregated;
			end else begin
				outcome = outcome_rejected; // another name holds the slot
			end
		end else begin
			outcome = hit ? outcome_satisfied : outcome_rejected; // rejected data is unsolicited
		end
	end

	////////////////////////////////////////////////////////////
	// update

	// read and write share the cycle, so a following lookup sees this one
	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
		end else if (lookup_valid) begin
			if (outcome == outcome_inserted) slot_valid[lookup.index] <= 1'b1;
			else if (outcome == outcome_satisfied) slot_valid[lookup.index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_valid && outcome == outcome_inserted) begin
			slot_request[lookup.index] <= lookup.request;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) result_valid <= 1'b0;
		else result_valid <= lookup_valid;
	end

	always_ff @(posedge clk) begin
		result.kind <= lookup.kind;
		result.outcome <= outcome;
		result.table_entry <= lookup.index;
	end

	// every lookup leaves the table on the very next edge
	assert property (@(posedge clk) disable iff (reset)
		lookup_valid |=> result_valid && result.table_entry == $past(lookup.index))
		else $error("lookup did not produce a result one cycle later");

endmodule

/* source/pit_ingress.sv */
module pit_ingress (
	input logic clk,
	input logic reset,
	input logic interest_valid,
	input pit_pkg::pit_request_t interest,
	input logic data_valid,
	input pit_pkg::pit_request_t data,
	output logic interest_credit,
	output logic data_credit,
	output logic pop_valid,
	output pit_pkg::pit_kind_e pop_kind,
	output pit_pkg::pit_request_t pop_request
);
	import pit_pkg::*;

	// channel 0 carries interests, channel 1 carries data
	logic [1:0] push_valid;
	pit_request_t push_request [2];
	pit_request_t head_request [2];
	logic [1:0] not_empty;
	logic [1:0] pop;

	assign push_valid = {data_valid, interest_valid};
	assign push_request[0] = interest;
	assign push_request[1] = data;

	////////////////////////////////////////////////////////////
	// queues

	for (genvar ch = 0; ch < 2; ch++) begin : g_queue
		pit_request_t storage [INGRESS_DEPTH];
		logic [INGRESS_PTR_BITS-1:0] head;
		logic [INGRESS_PTR_BITS-1:0] tail;
		logic [INGRESS_PTR_BITS:0] count;

		always_ff @(posedge clk) begin
			if (reset) begin
				head <= '0;
				tail <= '0;
				count <= '0;
			end else begin
				if (push_valid[ch]) tail <= tail + 1'b1; // depth is a power of two
				if (pop[ch]) head <= head + 1'b1;
				count <= count + push_valid[ch] - pop[ch];
			end
		end

		always_ff @(posedge clk) begin
			if (push_valid[ch]) storage[tail] <= push_request[ch];
		end

		assign head_request[ch] = storage[head];
		assign not_empty[ch] = count != 0;

		// the sender only pushes while it holds a credit
		assert property (@(posedge clk) disable iff (reset) push_valid[ch] |-> count != INGRESS_DEPTH)
			else $error("push into full ingress queue %0d", ch);
	end

	////////////////////////////////////////////////////////////
	// data-first arbiter

	assign pop[1] = not_empty[1];
	assign pop[0] = not_empty[0] && !not_empty[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			pop_valid <= 1'b0;
			interest_credit <= 1'b0;
			data_credit <= 1'b0;
		end else begin
			pop_valid <= |pop;
			interest_credit <= pop[0]; // one credit back per pop
			data_credit <= pop[1];
		end
	end

	always_ff @(posedge clk) begin
		pop_kind <= pop[1] ? kind_data : kind_interest;
		pop_request <= pop[1] ? head_request[1] : head_request[0];
	end

endmodule

/* source/pit_pkg.sv */
package pit_pkg;

	////////////////////////////////////////////////////////////
	// sizes

	localparam int PREFIX_BITS = 64;
	localparam int LEN_BITS = 7; // holds 0 to 64 leading bits
	localparam int INDEX_BITS = 6;
	localparam int TABLE_SLOTS = 1 << INDEX_BITS; // small on purpose so names collide
	localparam int INGRESS_DEPTH = 4;
	localparam int INGRESS_PTR_BITS = $clog2(INGRESS_DEPTH);
	localparam int OUTCOME_COUNT = 4;

	////////////////////////////////////////////////////////////
	// configuration map

	localparam int CFG_ADDR_BITS = 3;
	localparam int CFG_DATA_BITS = 32;
	localparam logic [CFG_ADDR_BITS-1:0] CFG_SALT = 3'd0;
	localparam logic [CFG_ADDR_BITS-1:0] CFG_INSERTED = 3'd1;
	localparam logic [CFG_ADDR_BITS-1:0] CFG_AGGREGATED = 3'd2;
	localparam logic [CFG_ADDR_BITS-1:0] CFG_SATISFIED = 3'd3;
	localparam logic [CFG_ADDR_BITS-1:0] CFG_REJECTED = 3'd4;

	////////////////////////////////////////////////////////////
	// types

	typedef struct packed {
		logic [PREFIX_BITS-1:0] prefix;
		logic [LEN_BITS-1:0] len;
	} pit_request_t;

	typedef enum logic {kind_interest, kind_data} pit_kind_e;

	typedef struct packed {
		pit_kind_e kind;
		pit_request_t request; // already masked to len
		logic [INDEX_BITS-1:0] index;
	} pit_lookup_t;

	// order matches the counter addresses minus one
	typedef enum logic [1:0] {
		outcome_inserted,
		outcome_aggregated,
		outcome_satisfied,
		outcome_rejected
	} pit_outcome_e;

	typedef struct packed {
		pit_kind_e kind;
		pit_outcome_e outcome;
		logic [INDEX_BITS-1:0] table_entry;
	} pit_result_t;

endpackage

/* source/pit_prefix_hash.sv */
module pit_prefix_hash (
	input logic clk,
	input logic reset,
	input logic pop_valid,
	input pit_pkg::pit_kind_e pop_kind,
	input pit_pkg::pit_request_t pop_request,
	input logic [pit_pkg::INDEX_BITS-1:0] salt,
	output logic lookup_valid,
	output pit_pkg::pit_lookup_t lookup
);
	import pit_pkg::*;

	logic [PREFIX_BITS-1:0] mask;
	logic [PREFIX_BITS-1:0] masked;
	logic [INDEX_BITS-1:0] fold;

	assign mask = ~({PREFIX_BITS{1'b1}} >> pop_request.len); // len of 64 shifts to all ones
	assign masked = pop_request.prefix & mask;

	// bit i lands in position i mod 6, so the short top chunk is zero-extended
	always_comb begin
		fold = '0;
		for (int i = 0; i < PREFIX_BITS; i++) begin
			fold[i % INDEX_BITS] ^= masked[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) lookup_valid <= 1'b0;
		else lookup_valid <= pop_valid;
	end

	always_ff @(posedge clk) begin
		lookup.kind <= pop_kind;
		lookup.request <= '{prefix: masked, len: pop_request.len};
		lookup.index <= fold ^ salt;
	end

	assert property (@(posedge clk) disable iff (reset) pop_valid |-> pop_request.len <= PREFIX_BITS)
		else $error("prefix length %0d exceeds %0d", pop_request.len, PREFIX_BITS);

endmodule

/* source/pit_top.sv */
module pit_top (
	input logic clk,
	input logic reset,
	input logic interest_valid,
	input pit_pkg::pit_request_t interest,
	input logic data_valid,
	input pit_pkg::pit_request_t data,
	output logic interest_credit,
	output logic data_credit,
	output logic result_valid,
	output pit_pkg::pit_result_t result,
	input logic cfg_write,
	input logic [pit_pkg::CFG_ADDR_BITS-1:0] cfg_addr,
	input logic [pit_pkg::CFG_DATA_BITS-1:0] cfg_wdata,
	output logic [pit_pkg::CFG_DATA_BITS-1:0] cfg_rdata
);
	import pit_pkg::*;

	logic pop_valid;
	pit_kind_e pop_kind;
	pit_request_t pop_request;
	logic lookup_valid;
	pit_lookup_t lookup;
	logic [INDEX_BITS-1:0] salt;

	pit_ingress i_ingress (
		.clk(clk),
		.reset(reset),
		.interest_valid(interest_valid),
		.interest(interest),
		.data_valid(data_valid),
		.data(data),
		.interest_credit(interest_credit),
		.data_credit(data_credit),
		.pop_valid(pop_valid),
		.pop_kind(pop_kind),
		.pop_request(pop_request)
	);

	pit_prefix_hash i_hash (
		.clk(clk),
		.reset(reset),
		.pop_valid(pop_valid),
		.pop_kind(pop_kind),
		.pop_request(pop_request),
		.salt(salt),
		.lookup_valid(lookup_valid),
		.lookup(lookup)
	);

	pit_hash_table i_table (
		.clk(clk),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup(lookup),
		.result_valid(result_valid),
		.result(result)
	);

	pit_config i_config (
		.clk(clk),
		.reset(reset),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.salt(salt),
		.result_valid(result_valid),
		.result(result)
	);

endmodule
